// ==== hw/decode_params.svh ====
// Decode stage constants
// Widths, reset PC, trap causes, unit positions, micro-op codes and
// operand/immediate select positions shared by the decode stage blocks
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN            32
`define PC_RESET_VALUE  32'h8000_0000

`define TRAP_IACCESS    5'd1        // Fetch error
`define TRAP_IOPCODE    5'd2        // Illegal encoding

// Bit positions in the one-hot unit vector
`define FU_ALU          0
`define FU_CFU          1
`define FU_LSU          2

// ALU micro-ops
`define ALU_ADD         5'd1
`define ALU_SUB         5'd2
`define ALU_AND         5'd3
`define ALU_OR          5'd4
`define ALU_XOR         5'd5
`define ALU_SLT         5'd6
`define ALU_SLTU        5'd7
`define ALU_SLL         5'd8
`define ALU_SRL         5'd9
`define ALU_SRA         5'd10

// Control-flow micro-ops
`define CFU_BEQ         5'd1
`define CFU_BNE         5'd2
`define CFU_BLT         5'd3
`define CFU_BGE         5'd4
`define CFU_BLTU        5'd5
`define CFU_BGEU        5'd6
`define CFU_JALI        5'd7
`define CFU_JALR        5'd8

// LSU micro-op, bits 2:1 carry the width
`define LSU_SIGNED      0
`define LSU_LOAD        3
`define LSU_STORE       4
`define LSU_BYTE        2'b01
`define LSU_HALF        2'b10
`define LSU_WORD        2'b11

// Operand source selects
`define OPR_A_RS1       0
`define OPR_A_PC        1
`define OPR_B_RS2       2
`define OPR_B_IMM       3
`define OPR_C_RS2       4
`define OPR_C_PCIM      5

// Immediate format selects
`define IMM_I           0
`define IMM_S           1
`define IMM_B           2
`define IMM_U           3
`define IMM_J           4

`endif

// ==== hw/decode_pkg.sv ====
// Decode stage types
// Vector types for the fields that travel between the decode blocks
// and out to execute
`include "decode_params.svh"

package decode_pkg;

    // Instruction words, register data, operands and PC values
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [4:0] reg_addr_t;     // Register file address

    typedef logic [4:0] uop_t;          // Micro-op within a unit

    // One-hot unit, see the FU_* positions
    typedef logic [2:0] fu_t;

    // One-hot operand selects, see the OPR_* positions
    typedef logic [5:0] opr_src_t;

    typedef logic [4:0] trap_cause_t;   // Carried in the rd field

endpackage

// ==== hw/instr_classifier.sv ====
// Instruction classifier
// Matches the opcode and funct fields of an RV32I word and produces the
// one-hot unit, the micro-op, the operand sources, the immediate format,
// the destination register and an illegal-encoding flag
`timescale 1ns/10ps
`include "decode_params.svh"

module instr_classifier import decode_pkg::*; (
    input  word_t      s1_data,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output reg_addr_t  rd_addr,
    output fu_t        fu,
    output uop_t       uop,
    output opr_src_t   opr_src,
    output logic [4:0] imm_sel,
    output logic       jal_taken,
    output logic       illegal
);

    wire [6:0] opc     = s1_data[6:0];
    wire [2:0] f3      = s1_data[14:12];
    wire       f7_zero = s1_data[31:25] == 7'b0000000;
    wire       f7_alt  = s1_data[31:25] == 7'b0100000;    // SUB and SRA

    wire op_reg    = opc == 7'b0110011;
    wire op_imm    = opc == 7'b0010011;
    wire op_load   = opc == 7'b0000011;
    wire op_store  = opc == 7'b0100011;
    wire op_branch = opc == 7'b1100011;

    // Individual instructions
    // ------------------------------
    wire dec_add   = op_reg && f3 == 3'd0 && f7_zero;
    wire dec_sub   = op_reg && f3 == 3'd0 && f7_alt;
    wire dec_sll   = op_reg && f3 == 3'd1 && f7_zero;
    wire dec_slt   = op_reg && f3 == 3'd2 && f7_zero;
    wire dec_sltu  = op_reg && f3 == 3'd3 && f7_zero;
    wire dec_xor   = op_reg && f3 == 3'd4 && f7_zero;
    wire dec_srl   = op_reg && f3 == 3'd5 && f7_zero;
    wire dec_sra   = op_reg && f3 == 3'd5 && f7_alt;
    wire dec_or    = op_reg && f3 == 3'd6 && f7_zero;
    wire dec_and   = op_reg && f3 == 3'd7 && f7_zero;
    wire dec_addi  = op_imm && f3 == 3'd0;
    wire dec_slli  = op_imm && f3 == 3'd1 && f7_zero;
    wire dec_slti  = op_imm && f3 == 3'd2;
    wire dec_sltiu = op_imm && f3 == 3'd3;
    wire dec_xori  = op_imm && f3 == 3'd4;
    wire dec_srli  = op_imm && f3 == 3'd5 && f7_zero;
    wire dec_srai  = op_imm && f3 == 3'd5 && f7_alt;
    wire dec_ori   = op_imm && f3 == 3'd6;
    wire dec_andi  = op_imm && f3 == 3'd7;
    wire dec_lui   = opc == 7'b0110111;
    wire dec_auipc = opc == 7'b0010111;
    wire dec_jal   = opc == 7'b1101111;
    wire dec_jalr  = opc == 7'b1100111 && f3 == 3'd0;

    wire dec_lb  = op_load && f3 == 3'd0;
    wire dec_lh  = op_load && f3 == 3'd1;
    wire dec_lw  = op_load && f3 == 3'd2;
    wire dec_lbu = op_load && f3 == 3'd4;
    wire dec_lhu = op_load && f3 == 3'd5;
    wire dec_sb  = op_store && f3 == 3'd0;
    wire dec_sh  = op_store && f3 == 3'd1;
    wire dec_sw  = op_store && f3 == 3'd2;

    wire dec_beq  = op_branch && f3 == 3'd0;
    wire dec_bne  = op_branch && f3 == 3'd1;
    wire dec_blt  = op_branch && f3 == 3'd4;
    wire dec_bge  = op_branch && f3 == 3'd5;
    wire dec_bltu = op_branch && f3 == 3'd6;
    wire dec_bgeu = op_branch && f3 == 3'd7;

    wire any_load   = dec_lb || dec_lh || dec_lw || dec_lbu || dec_lhu;
    wire any_store  = dec_sb || dec_sh || dec_sw;
    wire any_branch = dec_beq || dec_bne || dec_blt || dec_bge || dec_bltu || dec_bgeu;
    wire any_regop  = dec_add || dec_sub || dec_sll || dec_slt || dec_sltu ||
                      dec_xor || dec_srl || dec_sra || dec_or || dec_and;
    wire any_immop  = dec_addi || dec_slli || dec_slti || dec_sltiu || dec_xori ||
                      dec_srli || dec_srai || dec_ori || dec_andi;

    // Unit and micro-op
    // ------------------------------
    assign fu[`FU_ALU] = any_regop || any_immop || dec_lui || dec_auipc;
    assign fu[`FU_CFU] = any_branch || dec_jal || dec_jalr;
    assign fu[`FU_LSU] = any_load || any_store;

    wire uop_t uop_alu =
        {5{dec_add  || dec_addi || dec_auipc}} & `ALU_ADD  |
        {5{dec_sub                          }} & `ALU_SUB  |
        {5{dec_and  || dec_andi             }} & `ALU_AND  |
        {5{dec_or   || dec_ori  || dec_lui  }} & `ALU_OR   |   // LUI is 0 | imm
        {5{dec_xor  || dec_xori             }} & `ALU_XOR  |
        {5{dec_slt  || dec_slti             }} & `ALU_SLT  |
        {5{dec_sltu || dec_sltiu            }} & `ALU_SLTU |
        {5{dec_sll  || dec_slli             }} & `ALU_SLL  |
        {5{dec_srl  || dec_srli             }} & `ALU_SRL  |
        {5{dec_sra  || dec_srai             }} & `ALU_SRA;

    wire uop_t uop_cfu =
        {5{dec_beq }} & `CFU_BEQ  | {5{dec_bne }} & `CFU_BNE  |
        {5{dec_blt }} & `CFU_BLT  | {5{dec_bge }} & `CFU_BGE  |
        {5{dec_bltu}} & `CFU_BLTU | {5{dec_bgeu}} & `CFU_BGEU |
        {5{dec_jal }} & `CFU_JALI | {5{dec_jalr}} & `CFU_JALR;

    uop_t uop_lsu;
    assign uop_lsu[2:1] = {2{dec_lb || dec_lbu || dec_sb}} & `LSU_BYTE |
                          {2{dec_lh || dec_lhu || dec_sh}} & `LSU_HALF |
                          {2{dec_lw || dec_sw          }} & `LSU_WORD;
    assign uop_lsu[`LSU_LOAD]   = any_load;
    assign uop_lsu[`LSU_STORE]  = any_store;
    assign uop_lsu[`LSU_SIGNED] = dec_lb || dec_lh;

    assign uop = uop_alu | uop_cfu | uop_lsu;

    // Operands and immediate format
    // ------------------------------
    assign opr_src[`OPR_A_RS1]  = any_regop || any_immop || any_branch || dec_jalr ||
                                  any_load || any_store;
    assign opr_src[`OPR_A_PC]   = dec_auipc;
    assign opr_src[`OPR_B_RS2]  = any_regop || any_branch;
    assign opr_src[`OPR_B_IMM]  = any_immop || dec_lui || dec_auipc || dec_jalr ||
                                  any_load || any_store;
    assign opr_src[`OPR_C_RS2]  = any_store;                // Store data
    assign opr_src[`OPR_C_PCIM] = any_branch || dec_jal;    // Taken target

    assign imm_sel[`IMM_I] = any_immop || dec_jalr || any_load;
    assign imm_sel[`IMM_S] = any_store;
    assign imm_sel[`IMM_B] = any_branch;
    assign imm_sel[`IMM_U] = dec_lui || dec_auipc;
    assign imm_sel[`IMM_J] = dec_jal;

    assign rs1_addr  = s1_data[19:15];
    assign rs2_addr  = s1_data[24:20];
    assign rd_addr   = (any_store || any_branch || !(|fu)) ? 5'd0 : s1_data[11:7];
    assign jal_taken = dec_jal;
    assign illegal   = !(|fu) || s1_data[1:0] != 2'b11;

    always_comb begin
        a_fu_onehot: assert #0 ($onehot0(fu))
            else $error("instr_classifier: word %h maps to units %b", s1_data, fu);
    end

endmodule

// ==== hw/imm_gen.sv ====
// Immediate generator
// Builds the sign-extended I/S/B/U/J immediates of an RV32I word and
// selects the general immediate and the PC-relative one
`timescale 1ns/10ps
`include "decode_params.svh"

module imm_gen import decode_pkg::*; (
    input  word_t      s1_data,
    input  logic [4:0] imm_sel,
    output word_t      imm,
    output word_t      pc_imm
);

    wire word_t imm_i = {{20{s1_data[31]}}, s1_data[31:20]};
    wire word_t imm_s = {{20{s1_data[31]}}, s1_data[31:25], s1_data[11:7]};
    wire word_t imm_b = {{20{s1_data[31]}}, s1_data[7], s1_data[30:25],
                         s1_data[11:8], 1'b0};
    wire word_t imm_u = {s1_data[31:12], 12'b0};
    wire word_t imm_j = {{12{s1_data[31]}}, s1_data[19:12], s1_data[20],
                         s1_data[30:21], 1'b0};

    // Branch and jump offsets go to the PC adder
    assign pc_imm = {`XLEN{imm_sel[`IMM_B]}} & imm_b |
                    {`XLEN{imm_sel[`IMM_J]}} & imm_j;

    assign imm = pc_imm                           |
                 {`XLEN{imm_sel[`IMM_I]}} & imm_i |
                 {`XLEN{imm_sel[`IMM_S]}} & imm_s |
                 {`XLEN{imm_sel[`IMM_U]}} & imm_u;

    always_comb begin
        a_sel_onehot: assert #0 ($onehot0(imm_sel))
            else $error("imm_gen: several immediate formats selected %b", imm_sel);
    end

endmodule

// ==== hw/pc_tracker.sv ====
// Program counter tracker
// Holds the PC of the instruction in decode, adds the PC-relative
// immediate and raises the predicted-jump request for JAL, stalling
// decode until the fetch side acknowledges it
`timescale 1ns/10ps
`include "decode_params.svh"

module pc_tracker import decode_pkg::*; (
    input  logic  g_clk,
    input  logic  g_resetn,
    input  logic  advance,          // Instruction accepted this cycle
    input  logic  jal_taken,
    input  logic  s1_valid,
    input  logic  s1_bubble,
    input  logic  s2_busy,
    input  word_t pc_imm,
    input  logic  s1_cf_ack,
    input  logic  cf_req,
    input  logic  cf_ack,
    input  word_t cf_target,
    output word_t pc,
    output word_t pc_plus_imm,
    output logic  s1_cf_req,
    output word_t s1_cf_target,
    output logic  stall
);

    assign pc_plus_imm  = pc + pc_imm;
    assign s1_cf_target = pc_plus_imm;
    assign s1_cf_req    = s1_valid && jal_taken && !s1_bubble && !s2_busy;
    assign stall        = s1_cf_req && !s1_cf_ack;    // Wait for the ack

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `PC_RESET_VALUE;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;                // Redirect wins
        end else if (advance && s1_cf_req) begin
            pc <= s1_cf_target;             // Predicted JAL
        end else if (advance) begin
            pc <= pc + word_t'(4);
        end
    end

    // Fetch relies on a steady target while the request is pending
    a_target_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (stall && !(cf_req && cf_ack)) ##1 s1_cf_req |-> $stable(s1_cf_target));

endmodule

// ==== hw/decode_stage_reg.sv ====
// Decode to execute stage register
// One-entry register with a valid/busy pair, flush, and zeroing of the
// control fields when a bubble is inserted
`timescale 1ns/10ps
`include "decode_params.svh"

module decode_stage_reg import decode_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      flush,
    input  logic      n_valid,
    input  logic      bubble,
    input  reg_addr_t n_rd,
    input  word_t     n_opr_a,
    input  word_t     n_opr_b,
    input  word_t     n_opr_c,
    input  logic      n_cf_pred,
    input  uop_t      n_uop,
    input  fu_t       n_fu,
    input  logic      n_trap,
    input  word_t     n_instr,
    input  logic      s2_busy,
    output logic      stage_busy,
    output logic      s2_valid,
    output reg_addr_t s2_rd,
    output word_t     s2_opr_a,
    output word_t     s2_opr_b,
    output word_t     s2_opr_c,
    output logic      s2_cf_pred,
    output uop_t      s2_uop,
    output fu_t       s2_fu,
    output logic      s2_trap,
    output word_t     s2_instr
);

    assign stage_busy = s2_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            s2_valid <= 1'b0;
        end else if (!s2_busy) begin
            s2_valid <= n_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!s2_busy) begin
            s2_rd      <= bubble ? 5'd0 : n_rd;
            s2_uop     <= bubble ? 5'd0 : n_uop;
            s2_fu      <= bubble ? 3'd0 : n_fu;     // Bubble reaches no unit
            s2_trap    <= bubble ? 1'b0 : n_trap;
            s2_opr_a   <= n_opr_a;
            s2_opr_b   <= n_opr_b;
            s2_opr_c   <= n_opr_c;
            s2_cf_pred <= n_cf_pred;
            s2_instr   <= n_instr;
        end
    end

    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid && s2_busy && !flush |=> s2_valid &&
        $stable({s2_rd, s2_opr_a, s2_opr_b, s2_opr_c, s2_cf_pred,
                 s2_uop, s2_fu, s2_trap, s2_instr}));

endmodule

// ==== hw/decode_stage.sv ====
// Decode stage
// Takes a 32-bit RV32I word from fetch, reads the register file, builds
// the three operands and the unit/micro-op/destination fields, merges
// trap causes and registers the result towards execute
`timescale 1ns/10ps
`include "decode_params.svh"

module decode_stage import decode_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s1_valid,
    output logic      s1_busy,
    input  word_t     s1_data,
    input  logic      s1_error,         // Fetch error on this word
    input  logic      s1_flush,
    input  logic      s1_bubble,
    output reg_addr_t s1_rs1_addr,
    output reg_addr_t s1_rs2_addr,
    input  word_t     s1_rs1_rdata,
    input  word_t     s1_rs2_rdata,
    output logic      s1_cf_req,        // Predicted jump
    output word_t     s1_cf_target,
    input  logic      s1_cf_ack,
    input  logic      cf_req,           // External redirect
    input  word_t     cf_target,
    input  logic      cf_ack,
    output logic      s2_valid,
    input  logic      s2_busy,
    output reg_addr_t s2_rd,
    output word_t     s2_opr_a,
    output word_t     s2_opr_b,
    output word_t     s2_opr_c,
    output logic      s2_cf_pred,
    output uop_t      s2_uop,
    output fu_t       s2_fu,
    output logic      s2_trap,
    output word_t     s2_instr
);

    reg_addr_t   rd_addr;
    fu_t         fu;
    uop_t        uop;
    opr_src_t    opr_src;
    logic [4:0]  imm_sel;
    logic        jal_taken;
    logic        illegal;
    word_t       imm;
    word_t       pc_imm;
    word_t       pc;
    word_t       pc_plus_imm;
    logic        stall;
    logic        stage_busy;
    trap_cause_t trap_cause;

    assign s1_busy = stage_busy || s1_bubble || stall;

    wire advance = s1_valid && !s1_busy;
    wire n_valid = (s1_valid || s1_bubble) && !stall;

    // Traps and destination
    // ------------------------------
    wire n_trap = s1_valid && (s1_error || illegal);

    assign trap_cause = illegal  ? `TRAP_IOPCODE :
                        s1_error ? `TRAP_IACCESS : 5'd0;

    wire reg_addr_t n_rd  = n_trap ? trap_cause : rd_addr;
    wire fu_t       n_fu  = n_trap ? 3'd0 : fu;
    wire uop_t      n_uop = n_trap ? 5'd0 : uop;

    // Operand muxes
    // ------------------------------
    wire word_t n_opr_a = {`XLEN{opr_src[`OPR_A_RS1]}}  & s1_rs1_rdata |
                          {`XLEN{opr_src[`OPR_A_PC]}}   & pc;
    wire word_t n_opr_b = {`XLEN{opr_src[`OPR_B_RS2]}}  & s1_rs2_rdata |
                          {`XLEN{opr_src[`OPR_B_IMM]}}  & imm;
    wire word_t n_opr_c = {`XLEN{opr_src[`OPR_C_RS2]}}  & s1_rs2_rdata |
                          {`XLEN{opr_src[`OPR_C_PCIM]}} & pc_plus_imm;

    instr_classifier u_classifier (
        .s1_data(s1_data), .rs1_addr(s1_rs1_addr), .rs2_addr(s1_rs2_addr),
        .rd_addr(rd_addr), .fu(fu), .uop(uop), .opr_src(opr_src),
        .imm_sel(imm_sel), .jal_taken(jal_taken), .illegal(illegal)
    );

    imm_gen u_imm_gen (
        .s1_data(s1_data), .imm_sel(imm_sel), .imm(imm), .pc_imm(pc_imm)
    );

    pc_tracker u_pc_tracker (
        .g_clk(g_clk), .g_resetn(g_resetn), .advance(advance),
        .jal_taken(jal_taken), .s1_valid(s1_valid), .s1_bubble(s1_bubble),
        .s2_busy(s2_busy), .pc_imm(pc_imm), .s1_cf_ack(s1_cf_ack),
        .cf_req(cf_req), .cf_ack(cf_ack), .cf_target(cf_target),
        .pc(pc), .pc_plus_imm(pc_plus_imm), .s1_cf_req(s1_cf_req),
        .s1_cf_target(s1_cf_target), .stall(stall)
    );

    decode_stage_reg u_stage_reg (
        .g_clk(g_clk), .g_resetn(g_resetn), .flush(s1_flush),
        .n_valid(n_valid), .bubble(s1_bubble), .n_rd(n_rd),
        .n_opr_a(n_opr_a), .n_opr_b(n_opr_b), .n_opr_c(n_opr_c),
        .n_cf_pred(jal_taken), .n_uop(n_uop), .n_fu(n_fu), .n_trap(n_trap),
        .n_instr(s1_data), .s2_busy(s2_busy), .stage_busy(stage_busy),
        .s2_valid(s2_valid), .s2_rd(s2_rd), .s2_opr_a(s2_opr_a),
        .s2_opr_b(s2_opr_b), .s2_opr_c(s2_opr_c), .s2_cf_pred(s2_cf_pred),
        .s2_uop(s2_uop), .s2_fu(s2_fu), .s2_trap(s2_trap), .s2_instr(s2_instr)
    );

endmodule

// ==== bench/tb_decode.sv ====
// Decode stage testbench
// Drives RV32I words built from LFSR bits into the decode stage and
// checks the registered entry, the PC tracking, JAL prediction, traps,
// back-pressure, flush and bubbles with concurrent assertions
`timescale 1ns/10ps
`include "decode_params.svh"

module tb_decode import decode_pkg::*; ();

    localparam int TIMEOUT = 50;

    logic g_clk, g_resetn;
    logic s1_valid, s1_error, s1_flush, s1_bubble, s1_cf_ack;
    logic cf_req, cf_ack, s2_busy;
    word_t s1_data, cf_target, s1_rs1_rdata, s1_rs2_rdata;
    logic s1_busy, s1_cf_req, s2_valid, s2_cf_pred, s2_trap;
    reg_addr_t s1_rs1_addr, s1_rs2_addr, s2_rd;
    word_t s1_cf_target, s2_opr_a, s2_opr_b, s2_opr_c, s2_instr;
    uop_t s2_uop;
    fu_t s2_fu;

    // Expected entry and the copy taken when the word is accepted
    reg_addr_t exp_rd, chk_rd, prev_rd;
    word_t exp_a, exp_b, exp_c, chk_a, chk_b, chk_c, prev_a, exp_target;
    word_t chk_instr;
    uop_t exp_uop, chk_uop;
    fu_t exp_fu, chk_fu;
    logic exp_trap, chk_trap, exp_pred, chk_pred;
    word_t model_pc, jal_off;
    logic jal_flag;
    logic [31:0] lfsr;
    int errors;
    int reported;

    wire acc = s1_valid && !s1_busy;

    decode_stage u_decode_stage (.*);

    function automatic word_t reg_value(input reg_addr_t a);
        return word_t'(a) * 32'h0101_0101;
    endfunction

    // Register file model
    assign s1_rs1_rdata = reg_value(s1_rs1_addr);
    assign s1_rs2_rdata = reg_value(s1_rs2_addr);

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32,22,2,1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    function automatic word_t sext12(input logic [11:0] x);
        return {{20{x[11]}}, x};
    endfunction

    function automatic uop_t alu_uop(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? `ALU_SUB : `ALU_ADD;
            3'd1: return `ALU_SLL;
            3'd2: return `ALU_SLT;
            3'd3: return `ALU_SLTU;
            3'd4: return `ALU_XOR;
            3'd5: return alt ? `ALU_SRA : `ALU_SRL;
            3'd6: return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    task automatic check_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // PC model
    always @(posedge g_clk) begin
        if (!g_resetn) model_pc <= `PC_RESET_VALUE;
        else if (cf_req && cf_ack) model_pc <= cf_target;
        else if (acc && jal_flag) model_pc <= model_pc + jal_off;
        else if (acc) model_pc <= model_pc + 32'd4;
    end

    always @(posedge g_clk) begin
        prev_a  <= s2_opr_a;
        prev_rd <= s2_rd;
        if (acc) begin
            {chk_rd, chk_a, chk_b, chk_c} <= {exp_rd, exp_a, exp_b, exp_c};
            {chk_uop, chk_fu, chk_trap, chk_pred} <= {exp_uop, exp_fu, exp_trap, exp_pred};
            chk_instr <= s1_data;
        end
    end

    // Checks
    // ------------------------------
    a_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
        acc && !s1_flush |=> s2_valid) else check_fail("s2_valid", 0, 1);
    a_rd: assert property (@(posedge g_clk) disable iff (!g_resetn)
        acc |=> s2_rd == chk_rd) else check_fail("s2_rd", $sampled(s2_rd), $sampled(chk_rd));
    a_opr_a: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_opr_a == chk_a)
        else check_fail("s2_opr_a", $sampled(s2_opr_a), $sampled(chk_a));
    a_opr_b: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_opr_b == chk_b)
        else check_fail("s2_opr_b", $sampled(s2_opr_b), $sampled(chk_b));
    a_opr_c: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_opr_c == chk_c)
        else check_fail("s2_opr_c", $sampled(s2_opr_c), $sampled(chk_c));
    a_uop: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_uop == chk_uop)
        else check_fail("s2_uop", $sampled(s2_uop), $sampled(chk_uop));
    a_fu: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_fu == chk_fu)
        else check_fail("s2_fu", $sampled(s2_fu), $sampled(chk_fu));
    a_trap: assert property (@(posedge g_clk) disable iff (!g_resetn) acc |=> s2_trap == chk_trap)
        else check_fail("s2_trap", $sampled(s2_trap), $sampled(chk_trap));
    a_pred: assert property (@(posedge g_clk) disable iff (!g_resetn)
        acc |=> s2_cf_pred == chk_pred)
        else check_fail("s2_cf_pred", $sampled(s2_cf_pred), $sampled(chk_pred));
    a_instr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        acc |=> s2_instr == chk_instr)
        else check_fail("s2_instr", $sampled(s2_instr), $sampled(chk_instr));
    a_target: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_cf_req |-> s1_cf_target == exp_target)
        else check_fail("s1_cf_target", $sampled(s1_cf_target), $sampled(exp_target));
    a_stall_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_cf_req && !s1_cf_ack |-> s1_busy) else check_fail("s1_busy", 0, 1);
    a_stall_empty: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_cf_req && !s1_cf_ack && !s1_flush |=> !s2_valid) else check_fail("s2_valid", 1, 0);
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid && s2_busy && !s1_flush |=> s2_opr_a == prev_a && s2_rd == prev_rd)
        else check_fail("s2_opr_a held", $sampled(s2_opr_a), $sampled(prev_a));
    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_flush |=> !s2_valid) else check_fail("s2_valid after flush", 1, 0);
    a_bubble: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_bubble && !s2_busy && !s1_flush |=> s2_valid &&
        {s2_trap, s2_fu, s2_uop, s2_rd} == '0)
        else check_fail("bubble fields", $sampled({s2_trap, s2_fu, s2_uop, s2_rd}), 0);

    // Stimulus
    // ------------------------------
    task automatic set_exp(input reg_addr_t rd, input word_t a, input word_t b, input word_t c,
                           input uop_t uop, input int unit, input logic trap, input logic pred);
        exp_rd = rd;
        exp_a = a;
        exp_b = b;
        exp_c = c;
        exp_uop = uop;
        exp_fu = (unit < 0) ? 3'd0 : fu_t'(1 << unit);
        exp_trap = trap;
        exp_pred = pred;
    endtask

    // Present a word and wait until decode takes it
    task automatic send(input word_t word, input logic err);
        int n;
        n = 0;
        s1_data = word;
        s1_error = err;
        s1_valid = 1'b1;
        @(posedge g_clk);
        while (!acc && n < TIMEOUT) begin
            @(posedge g_clk);
            n++;
        end
        if (n == TIMEOUT) timeout_fail("instruction acceptance");
        @(negedge g_clk);
        s1_valid = 1'b0;
        s1_error = 1'b0;
    endtask

    task automatic probe_pc();
        logic [19:0] u;
        reg_addr_t rd;
        u = rand_bits(20);
        rd = rand_bits(5);
        set_exp(rd, model_pc, {u, 12'b0}, 0, `ALU_ADD, `FU_ALU, 0, 0);
        send({u, rd, 7'b0010111}, 0);                  // AUIPC
    endtask

    task automatic alu_forms();
        reg_addr_t rd, rs1, rs2;
        logic [2:0] f3;
        logic alt, use_imm;
        logic [11:0] i12;
        logic [6:0] f7;
        logic [19:0] u;
        for (int i = 0; i < 12; i++) begin
            {rd, rs1, rs2} = rand_bits(15);
            f3 = rand_bits(3);
            alt = rand_bits(1);
            use_imm = rand_bits(1);
            if ((f3 != 3'd0 && f3 != 3'd5) || (use_imm && f3 == 3'd0)) alt = 1'b0;
            f7 = alt ? 7'b0100000 : 7'b0;
            if (!use_imm) begin
                set_exp(rd, reg_value(rs1), reg_value(rs2), 0, alu_uop(f3, alt), `FU_ALU, 0, 0);
                send({f7, rs2, rs1, f3, rd, 7'b0110011}, 0);
            end else begin
                i12 = rand_bits(12);
                if (f3 == 3'd1 || f3 == 3'd5) i12[11:5] = f7;
                set_exp(rd, reg_value(rs1), sext12(i12), 0, alu_uop(f3, alt), `FU_ALU, 0, 0);
                send({i12, rs1, f3, rd, 7'b0010011}, 0);
            end
        end
        u = rand_bits(20);
        set_exp(rd, 0, {u, 12'b0}, 0, `ALU_OR, `FU_ALU, 0, 0);
        send({u, rd, 7'b0110111}, 0);                  // LUI
        probe_pc();
    endtask

    task automatic load_store();
        reg_addr_t rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] i12;
        logic [2:0] ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        uop_t uop;
        for (int i = 0; i < 8; i++) begin
            {rd, rs1, rs2} = rand_bits(15);
            i12 = rand_bits(12);
            f3 = ld_f3[i % 5];
            uop = {2'b01, f3[1:0] + 2'd1, f3 < 3'd2};
            set_exp(rd, reg_value(rs1), sext12(i12), 0, uop, `FU_LSU, 0, 0);
            send({i12, rs1, f3, rd, 7'b0000011}, 0);
            f3 = i % 3;
            uop = {2'b10, f3[1:0] + 2'd1, 1'b0};
            set_exp(0, reg_value(rs1), sext12(i12), reg_value(rs2), uop, `FU_LSU, 0, 0);
            send({i12[11:5], rs2, rs1, f3, i12[4:0], 7'b0100011}, 0);
        end
    endtask

    task automatic branches();
        reg_addr_t rs1, rs2;
        logic [11:0] off;
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        uop_t br_uop [6] = '{`CFU_BEQ, `CFU_BNE, `CFU_BLT, `CFU_BGE, `CFU_BLTU, `CFU_BGEU};
        word_t bimm;
        for (int i = 0; i < 8; i++) begin
            {rs1, rs2} = rand_bits(10);
            off = rand_bits(12);                       // Offset bits 12:1
            bimm = {{19{off[11]}}, off, 1'b0};
            set_exp(0, reg_value(rs1), reg_value(rs2), model_pc + bimm,
                    br_uop[i % 6], `FU_CFU, 0, 0);
            send({off[11], off[9:4], rs2, rs1, br_f3[i % 6], off[3:0], off[10], 7'b1100011}, 0);
        end
        probe_pc();
    endtask

    task automatic jal_prediction();
        logic [19:0] off;
        logic [29:0] word_addr;
        reg_addr_t rd;
        int n;
        for (int i = 0; i < 3; i++) begin
            off = rand_bits(20);
            rd = rand_bits(5);
            jal_off = {{11{off[19]}}, off, 1'b0};
            exp_target = model_pc + jal_off;
            set_exp(rd, 0, 0, exp_target, `CFU_JALI, `FU_CFU, 0, 1);
            jal_flag = 1'b1;
            s1_data = {off[19], off[9:0], off[10], off[18:11], rd, 7'b1101111};
            s1_valid = 1'b1;
            n = 0;
            @(posedge g_clk);
            while (!s1_cf_req && n < TIMEOUT) begin
                @(posedge g_clk);
                n++;
            end
            if (n == TIMEOUT) timeout_fail("predicted jump request");
            repeat (3) @(negedge g_clk);               // Ack withheld
            s1_cf_ack = 1'b1;
            send(s1_data, 0);
            s1_cf_ack = 1'b0;
            jal_flag = 1'b0;
            probe_pc();
        end
        word_addr = rand_bits(30);
        cf_target = {word_addr, 2'b00};
        cf_req = 1'b1;
        cf_ack = 1'b1;
        @(negedge g_clk);
        cf_req = 1'b0;
        cf_ack = 1'b0;
        probe_pc();
    endtask

    task automatic traps();
        logic [11:0] i12;
        reg_addr_t rs1;
        i12 = rand_bits(12);
        rs1 = rand_bits(5);
        set_exp(`TRAP_IOPCODE, 0, 0, 0, 0, -1, 1, 0);
        send(32'h0000_0000, 0);
        set_exp(`TRAP_IACCESS, reg_value(rs1), sext12(i12), 0, 0, -1, 1, 0);
        send({i12, rs1, 3'd0, 5'd7, 7'b0010011}, 1);  // ADDI with fetch error
        set_exp(`TRAP_IOPCODE, 0, 0, 0, 0, -1, 1, 0);
        send(32'hffff_fffc, 1);
    endtask

    task automatic pipeline_control();
        reg_addr_t rd, rs1, rs2;
        {rd, rs1, rs2} = rand_bits(15);
        set_exp(rd, reg_value(rs1), reg_value(rs2), 0, `ALU_ADD, `FU_ALU, 0, 0);
        send({7'b0, rs2, rs1, 3'd0, rd, 7'b0110011}, 0);
        s2_busy = 1'b1;
        set_exp(rs2, reg_value(rd), reg_value(rs1), 0, `ALU_XOR, `FU_ALU, 0, 0);
        s1_data = {7'b0, rs1, rd, 3'd4, rs2, 7'b0110011};
        s1_valid = 1'b1;
        repeat (4) @(negedge g_clk);                   // Entry held
        s2_busy = 1'b0;
        send(s1_data, 0);
        s1_flush = 1'b1;
        @(negedge g_clk);
        s1_flush = 1'b0;
        s1_bubble = 1'b1;
        s1_valid = 1'b1;                               // Trapping word held off
        s1_error = 1'b1;
        @(negedge g_clk);
        s1_bubble = 1'b0;
        s1_valid = 1'b0;
        s1_error = 1'b0;
        @(negedge g_clk);
    endtask

    task automatic report(input string name);
        $display("%-10s done, %0d errors", name, errors - reported);
        reported = errors;
    endtask

    initial begin
        lfsr = 32'h3665582a;
        errors = 0;
        reported = 0;
        g_resetn = 1'b0;
        {s1_valid, s1_error, s1_flush, s1_bubble, s1_cf_ack} = '0;
        {cf_req, cf_ack, s2_busy, jal_flag} = '0;
        s1_data = '0;
        cf_target = '0;
        jal_off = '0;
        exp_target = '0;
        set_exp(0, 0, 0, 0, 0, -1, 0, 0);
        repeat (5) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        alu_forms();
        report("alu");
        load_store();
        report("lsu");
        branches();
        report("branch");
        jal_prediction();
        report("jal");
        traps();
        report("trap");
        pipeline_control();
        report("flow");
        repeat (3) @(negedge g_clk);
        $display("Tests run: 6, errors: %0d", errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/decode_pkg.sv
hw/instr_classifier.sv
hw/imm_gen.sv
hw/pc_tracker.sv
hw/decode_stage_reg.sv
hw/decode_stage.sv
bench/tb_decode.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/decode_pkg.sv
      - hw/instr_classifier.sv
      - hw/imm_gen.sv
      - hw/pc_tracker.sv
      - hw/decode_stage_reg.sv
      - hw/decode_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_decode.sv
